// File: logic/cop_isa_pkg.sv
// ======================================
// cop_isa_pkg
// opcode and pack width encodings plus
// operation word field layout
// ======================================
`default_nettype none

package cop_isa_pkg;

    typedef enum logic [2:0] {
        OP_PADD = 3'd0,  // packed add
        OP_PSUB = 3'd1,  // packed subtract
        OP_PSLL = 3'd2,  // packed shift left
        OP_PSRL = 3'd3,  // packed shift right
        OP_PROR = 3'd4   // packed rotate right
    } cop_op_t;          // 5..7 illegal

    typedef enum logic [2:0] {
        PW_1  = 3'd1,    // one 32-bit word
        PW_2  = 3'd2,    // 16-bit halfwords
        PW_4  = 3'd3,    // bytes
        PW_8  = 3'd4,    // nibbles
        PW_16 = 3'd5     // 2-bit crumbs
    } cop_pw_t;          // 0, 6, 7 illegal

    // operation word fields, everything above bit 12 is ignored
    localparam int unsigned F_OP_LO   = 0;
    localparam int unsigned F_OP_HI   = 2;
    localparam int unsigned F_PW_LO   = 3;
    localparam int unsigned F_PW_HI   = 5;
    localparam int unsigned F_USE_IMM = 6;
    localparam int unsigned F_IMM_LO  = 7;
    localparam int unsigned F_IMM_HI  = 12;

endpackage

`default_nettype wire

// File: logic/cop_pipe_pkg.sv
// ======================================
// cop_pipe_pkg
// error causes and lane width constants
// ======================================
`default_nettype none

package cop_pipe_pkg;

    typedef enum logic [1:0] {
        CAUSE_NONE   = 2'd0,
        CAUSE_OPCODE = 2'd1,  // wins over a pack error
        CAUSE_PACK   = 2'd2
    } cop_cause_t;

    localparam int unsigned DATA_W   = 32;  // operand width
    localparam int unsigned SHAMT_W  = 6;   // shift amount width

    localparam int unsigned LW_WORD  = 32;  // PW_1 lane
    localparam int unsigned LW_HALF  = 16;  // PW_2 lane
    localparam int unsigned LW_BYTE  = 8;   // PW_4 lane
    localparam int unsigned LW_NIB   = 4;   // PW_8 lane
    localparam int unsigned LW_CRUMB = 2;   // PW_16 lane

endpackage

`default_nettype wire

// File: logic/cop_palu_shifter.sv
// ======================================
// cop_palu_shifter
// packed shift left, shift right and
// rotate right for all five lane widths
// ======================================
`default_nettype none

module cop_palu_shifter
    import cop_isa_pkg::*, cop_pipe_pkg::*;
(
    input  logic [DATA_W-1:0]  a,      // value to shift
    input  logic [SHAMT_W-1:0] shamt,  // shift amount
    input  cop_pw_t            pw,     // pack width
    input  logic               sl,     // shift left / n shift right
    input  logic               rot,    // rotate right / n shift
    output logic [DATA_W-1:0]  c
);

    // lane width per result slot, slot order follows PW_1 .. PW_16
    localparam int unsigned NUM_PW = 5;
    localparam int unsigned LANE_W [NUM_PW] = '{LW_WORD, LW_HALF, LW_BYTE, LW_NIB, LW_CRUMB};

    logic [DATA_W-1:0] res_w [NUM_PW];

    for (genvar w = 0; w < NUM_PW; w++) begin : g_width
        localparam int unsigned LW = LANE_W[w];
        localparam int unsigned AW = $clog2(LW);   // bits for amount mod LW

        logic [DATA_W-1:0] res;

        for (genvar l = 0; l < DATA_W / LW; l++) begin : g_lane
            logic [LW-1:0]   lane;
            logic [2*LW-1:0] rot_full;

            assign lane     = a[l*LW +: LW];
            assign rot_full = {lane, lane} >> shamt[AW-1:0];  // wraps in lane

            // a plain shift by LW or more clears the lane
            assign res[l*LW +: LW] = rot ? rot_full[LW-1:0] :
                                     sl  ? (lane << shamt)  :
                                           (lane >> shamt);
        end

        assign res_w[w] = res;
    end

    always_comb begin
        case (pw)
            PW_1:    c = res_w[0];
            PW_2:    c = res_w[1];
            PW_4:    c = res_w[2];
            PW_8:    c = res_w[3];
            PW_16:   c = res_w[4];
            default: c = '0;         // illegal width, zeroed later anyway
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cop_palu_adder.sv
// ======================================
// cop_palu_adder
// packed add and subtract, carries cut
// at every lane edge
// ======================================
`default_nettype none

module cop_palu_adder
    import cop_isa_pkg::*, cop_pipe_pkg::*;
(
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  cop_pw_t           pw,
    input  logic              sub,  // a - b when set
    output logic [DATA_W-1:0] c
);

    logic [DATA_W-1:0] bx;          // b or its inverse
    logic [DATA_W-1:0] lane_start;  // bit starts a new lane
    int unsigned       lw;

    assign bx = sub ? ~b : b;

    always_comb begin
        case (pw)
            PW_2:    lw = LW_HALF;
            PW_4:    lw = LW_BYTE;
            PW_8:    lw = LW_NIB;
            PW_16:   lw = LW_CRUMB;
            default: lw = LW_WORD;
        endcase
    end

    always_comb begin
        for (int i = 0; i < DATA_W; i++)
            lane_start[i] = (i & (lw - 1)) == 0;  // lw is a power of two
    end

    // ripple chain; at a lane start the carry in is replaced by sub
    always_comb begin
        logic carry;
        logic cin;
        carry = 1'b0;
        for (int i = 0; i < DATA_W; i++) begin
            cin   = lane_start[i] ? sub : carry;
            c[i]  = a[i] ^ bx[i] ^ cin;
            carry = (a[i] & bx[i]) | (cin & (a[i] ^ bx[i]));
        end
    end

endmodule

`default_nettype wire

// File: logic/cop_palu_decode.sv
// ======================================
// cop_palu_decode
// splits the operation word, picks the
// shift amount, classifies bad words
// ======================================
`default_nettype none

module cop_palu_decode
    import cop_isa_pkg::*, cop_pipe_pkg::*;
#(
    parameter bit PW16_EN = 1'b1     // allow crumb lanes
) (
    input  logic               g_clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  logic [DATA_W-1:0]  in_word,
    input  logic [DATA_W-1:0]  in_a,
    input  logic [DATA_W-1:0]  in_b,
    output logic               dec_valid,
    output cop_op_t            dec_op,
    output cop_pw_t            dec_pw,
    output logic [SHAMT_W-1:0] dec_shamt,
    output logic [DATA_W-1:0]  dec_a,
    output logic [DATA_W-1:0]  dec_b,
    output cop_cause_t         dec_cause
);

    logic [2:0]         op_raw;
    logic [2:0]         pw_raw;
    logic               use_imm;
    logic [SHAMT_W-1:0] shamt;
    logic               op_bad;
    logic               pw_bad;
    cop_cause_t         cause;

    assign op_raw  = in_word[F_OP_HI:F_OP_LO];
    assign pw_raw  = in_word[F_PW_HI:F_PW_LO];
    assign use_imm = in_word[F_USE_IMM];
    assign shamt   = use_imm ? in_word[F_IMM_HI:F_IMM_LO] : in_b[SHAMT_W-1:0];

    assign op_bad = op_raw > OP_PROR;                     // codes 5..7
    assign pw_bad = (pw_raw < PW_1) || (pw_raw > PW_16) ||
                    (!PW16_EN && (pw_raw == PW_16));      // crumbs switched off

    assign cause = op_bad ? CAUSE_OPCODE :
                   pw_bad ? CAUSE_PACK   : CAUSE_NONE;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec_cause <= CAUSE_NONE;
        end else begin
            dec_valid <= in_valid;
            if (in_valid)
                dec_cause <= cause;
        end
    end

    always_ff @(posedge g_clk) begin
        if (in_valid) begin                               // payload only on a strobe
            dec_op    <= cop_op_t'(op_raw);
            dec_pw    <= cop_pw_t'(pw_raw);
            dec_shamt <= shamt;
            dec_a     <= in_a;
            dec_b     <= in_b;
        end
    end

    a_legal_pw : assert property (@(posedge g_clk) disable iff (!arst_n)
        (dec_valid && dec_cause == CAUSE_NONE) |->
            (dec_pw inside {PW_1, PW_2, PW_4, PW_8, PW_16}) &&
            (PW16_EN || dec_pw != PW_16));

endmodule

`default_nettype wire

// File: logic/cop_palu_execute.sv
// ======================================
// cop_palu_execute
// runs adder or shifter, registers the
// lane result with its cause
// ======================================
`default_nettype none

module cop_palu_execute
    import cop_isa_pkg::*, cop_pipe_pkg::*;
(
    input  logic               g_clk,
    input  logic               arst_n,
    input  logic               dec_valid,
    input  cop_op_t            dec_op,
    input  cop_pw_t            dec_pw,
    input  logic [SHAMT_W-1:0] dec_shamt,
    input  logic [DATA_W-1:0]  dec_a,
    input  logic [DATA_W-1:0]  dec_b,
    input  cop_cause_t         dec_cause,
    output logic               ex_valid,
    output logic [DATA_W-1:0]  ex_data,
    output cop_cause_t         ex_cause
);

    logic              sl;
    logic              rot;
    logic              sub;
    logic              use_add;
    logic [DATA_W-1:0] sh_c;
    logic [DATA_W-1:0] add_c;
    logic [DATA_W-1:0] ex_next;

    assign sl      = dec_op == OP_PSLL;
    assign rot     = dec_op == OP_PROR;
    assign sub     = dec_op == OP_PSUB;
    assign use_add = (dec_op == OP_PADD) || (dec_op == OP_PSUB);

    cop_palu_shifter u_shifter (
        .a     (dec_a),
        .shamt (dec_shamt),
        .pw    (dec_pw),
        .sl    (sl),
        .rot   (rot),
        .c     (sh_c)
    );

    cop_palu_adder u_adder (
        .a   (dec_a),
        .b   (dec_b),
        .pw  (dec_pw),
        .sub (sub),
        .c   (add_c)
    );

    assign ex_next = (dec_cause != CAUSE_NONE) ? '0 :    // bad word gives zero
                     use_add ? add_c : sh_c;

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_cause <= CAUSE_NONE;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid)
                ex_cause <= dec_cause;
        end
    end

    always_ff @(posedge g_clk) begin
        if (dec_valid)
            ex_data <= ex_next;
    end

    a_ex_follows : assert property (@(posedge g_clk) disable iff (!arst_n)
        dec_valid |=> ex_valid);

endmodule

`default_nettype wire

// File: logic/cop_palu_result.sv
// ======================================
// cop_palu_result
// writeback register toward the core
// ======================================
`default_nettype none

module cop_palu_result
    import cop_pipe_pkg::*;
(
    input  logic              g_clk,
    input  logic              arst_n,
    input  logic              ex_valid,
    input  logic [DATA_W-1:0] ex_data,
    input  cop_cause_t        ex_cause,
    output logic              wb_valid,
    output logic [DATA_W-1:0] wb_data,
    output cop_cause_t        wb_cause
);

    // data and cause hold between strobes so the core may sample late
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_data  <= '0;
            wb_cause <= CAUSE_NONE;
        end else begin
            wb_valid <= ex_valid;       // one-cycle strobe
            if (ex_valid) begin
                wb_data  <= ex_data;
                wb_cause <= ex_cause;
            end
        end
    end

    a_err_zero : assert property (@(posedge g_clk) disable iff (!arst_n)
        (wb_valid && wb_cause != CAUSE_NONE) |-> (wb_data == '0));

endmodule

`default_nettype wire

// File: logic/cop_palu_top.sv
// ======================================
// cop_palu_top
// three stage packed ALU, decode to
// execute to writeback
// ======================================
`default_nettype none

module cop_palu_top
    import cop_isa_pkg::*, cop_pipe_pkg::*;
#(
    parameter bit PW16_EN = 1'b1
) (
    input  logic              g_clk,
    input  logic              arst_n,
    input  logic              in_valid,   // one-cycle strobe
    input  logic [DATA_W-1:0] in_word,
    input  logic [DATA_W-1:0] in_a,
    input  logic [DATA_W-1:0] in_b,
    output logic              wb_valid,
    output logic [DATA_W-1:0] wb_data,
    output cop_cause_t        wb_cause
);

    logic               dec_valid;
    cop_op_t            dec_op;
    cop_pw_t            dec_pw;
    logic [SHAMT_W-1:0] dec_shamt;
    logic [DATA_W-1:0]  dec_a;
    logic [DATA_W-1:0]  dec_b;
    cop_cause_t         dec_cause;
    logic               ex_valid;
    logic [DATA_W-1:0]  ex_data;
    cop_cause_t         ex_cause;

    cop_palu_decode #(.PW16_EN(PW16_EN)) u_decode (
        .g_clk, .arst_n, .in_valid, .in_word, .in_a, .in_b,
        .dec_valid, .dec_op, .dec_pw, .dec_shamt, .dec_a, .dec_b, .dec_cause
    );

    cop_palu_execute u_execute (
        .g_clk, .arst_n,
        .dec_valid, .dec_op, .dec_pw, .dec_shamt, .dec_a, .dec_b, .dec_cause,
        .ex_valid, .ex_data, .ex_cause
    );

    cop_palu_result u_result (
        .g_clk, .arst_n, .ex_valid, .ex_data, .ex_cause,
        .wb_valid, .wb_data, .wb_cause
    );

endmodule

`default_nettype wire

// File: testbench/tb_cop_palu_top.sv
// ======================================
// tb_cop_palu_top
// drives the packed ALU, models each
// lane and checks every writeback
// ======================================
`default_nettype none

module tb_cop_palu_top
    import cop_pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_PERIOD = 40;
    localparam int unsigned N_ADDSUB   = 5 * 2 * 8;
    localparam int unsigned N_SHIFT    = 3 * 5 * 7 * 2;
    localparam int unsigned N_MIXED    = 60;
    localparam int unsigned N_ILLEGAL  = 27;
    localparam int unsigned N_OPS      = N_ADDSUB + N_SHIFT + N_MIXED + N_ILLEGAL;
    localparam int unsigned MARGIN     = 100;  // reset plus drain cycles

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  cause;
        logic [31:0] cyc;
    } exp_t;

    logic        g_clk;
    logic        arst_n;
    logic        in_valid;
    logic [31:0] in_word;
    logic [31:0] in_a;
    logic [31:0] in_b;
    logic        wb_valid;
    logic [31:0] wb_data;
    cop_cause_t  wb_cause;

    exp_t        exp_q[$];
    logic [31:0] cyc;
    int unsigned err_count;
    int unsigned check_count;
    int unsigned err_mark;

    cop_palu_top #(.PW16_EN(1'b1)) uut (
        .g_clk, .arst_n, .in_valid, .in_word, .in_a, .in_b,
        .wb_valid, .wb_data, .wb_cause
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial cyc = '0;
    always @(posedge g_clk) cyc <= cyc + 1;

    // expected {cause, data} from the lane rules
    function automatic logic [33:0] ref_palu(input logic [31:0] word,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
        int unsigned     op;
        int unsigned     pw;
        int unsigned     amt;
        int unsigned     lw;
        int unsigned     s;
        longint unsigned mask;
        longint unsigned la;
        longint unsigned lb;
        longint unsigned r;
        longint unsigned res;
        op  = word[2:0];
        pw  = word[5:3];
        amt = word[6] ? word[12:7] : b[5:0];
        if (op > 4)
            return {CAUSE_OPCODE, 32'h0};        // opcode wins
        if (pw < 1 || pw > 5)
            return {CAUSE_PACK, 32'h0};
        lw   = 32 >> (pw - 1);
        mask = (64'd1 << lw) - 1;
        res  = 0;
        for (int l = 0; l < 32 / lw; l++) begin
            la = (a >> (l * lw)) & mask;
            lb = (b >> (l * lw)) & mask;
            case (op)
                0: r = (la + lb) & mask;
                1: r = (la - lb) & mask;         // wraps within the lane
                2: r = (amt >= lw) ? 0 : ((la << amt) & mask);
                3: r = (amt >= lw) ? 0 : (la >> amt);
                default: begin
                    s = amt % lw;
                    r = ((la >> s) | (la << (lw - s))) & mask;
                end
            endcase
            res = res | (r << (l * lw));
        end
        return {CAUSE_NONE, res[31:0]};
    endfunction

    function automatic logic [31:0] make_word(input int unsigned op, input int unsigned pw,
                                              input bit use_imm, input int unsigned imm);
        logic [31:0] w;
        w       = $urandom();                    // ignored upper bits stay random
        w[12:0] = {imm[5:0], use_imm, pw[2:0], op[2:0]};
        return w;
    endfunction

    task automatic check_val(input string msg, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0d ns: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic issue_op(input logic [31:0] word, input logic [31:0] a,
                            input logic [31:0] b);
        exp_t        e;
        logic [33:0] r;
        @(posedge g_clk);
        #2;
        in_valid = 1'b1;
        in_word  = word;
        in_a     = a;
        in_b     = b;
        r        = ref_palu(word, a, b);
        e.data   = r[31:0];
        e.cause  = r[33:32];
        e.cyc    = cyc;                          // edge count at drive time
        exp_q.push_back(e);
    endtask

    task automatic drain();
        @(posedge g_clk);
        #2 in_valid = 1'b0;
        while (exp_q.size() != 0)
            @(negedge g_clk);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, err_count - err_mark);
        err_mark = err_count;
    endtask

    // compare writebacks in order at the falling edge
    initial begin : compare
        exp_t e;
        forever begin
            @(negedge g_clk);
            if (wb_valid) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("writeback strobe at %0d ns with no operation outstanding",
                             $time);
                end else begin
                    e = exp_q.pop_front();
                    check_val("wb_data", wb_data, e.data);
                    check_val("wb_cause", 32'(wb_cause), 32'(e.cause));
                    check_val("latency", cyc, e.cyc + 3);
                end
            end
        end
    end

    initial begin : watchdog
        #((N_OPS * 4 + MARGIN) * CLK_PERIOD);
        $display("timeout, %0d operations still waiting for writeback", exp_q.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        int unsigned lw;
        int unsigned amts [7];
        void'($urandom(41564));
        err_count   = 0;
        check_count = 0;
        err_mark    = 0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_word     = '0;
        in_a        = '0;
        in_b        = '0;

        repeat (4) begin                         // reset held 4 cycles
            @(negedge g_clk);
            check_val("reset wb_valid", 32'(wb_valid), 32'h0);
            check_val("reset wb_data", wb_data, 32'h0);
        end
        @(posedge g_clk);
        #2 arst_n = 1'b1;
        repeat (2) begin
            @(negedge g_clk);
            check_val("idle wb_valid", 32'(wb_valid), 32'h0);
            check_val("idle wb_data", wb_data, 32'h0);
        end
        end_test("reset");

        for (int pw = 1; pw <= 5; pw++) begin
            for (int op = 0; op <= 1; op++) begin
                issue_op(make_word(op, pw, 0, 0), 32'hffff_ffff, $urandom() | 32'h1);
                issue_op(make_word(op, pw, 0, 0), 32'h0, $urandom() | 32'h1);
                repeat (6)
                    issue_op(make_word(op, pw, $urandom() % 2, $urandom()),
                             $urandom(), $urandom());
            end
        end
        drain();
        end_test("add_sub");

        for (int pw = 1; pw <= 5; pw++) begin
            lw   = 32 >> (pw - 1);
            amts = '{0, 1, lw - 1, lw, lw + 1, 63, $urandom() % 64};
            for (int op = 2; op <= 4; op++) begin
                foreach (amts[i]) begin
                    b = ($urandom() & ~32'h3f) | amts[i];
                    issue_op(make_word(op, pw, 0, $urandom()), $urandom(), b);
                    issue_op(make_word(op, pw, 1, amts[i]), $urandom(), $urandom());
                end
            end
        end
        drain();
        end_test("shift_rotate");

        repeat (N_MIXED) begin
            a = $urandom();
            b = $urandom();
            issue_op(make_word($urandom() % 5, 1 + $urandom() % 5, $urandom() % 2,
                               $urandom()), a, b);
        end
        drain();
        end_test("back_to_back");

        for (int op = 5; op <= 7; op++) begin
            issue_op(make_word(op, 1, 0, 0), $urandom(), $urandom());
            issue_op(make_word(op, 3, 1, 5), $urandom(), $urandom());
        end
        for (int op = 0; op <= 4; op++) begin
            issue_op(make_word(op, 0, 0, 0), $urandom(), $urandom());
            issue_op(make_word(op, 6, 0, 0), $urandom(), $urandom());
            issue_op(make_word(op, 7, 1, 3), $urandom(), $urandom());
        end
        for (int op = 5; op <= 7; op++) begin   // both fields bad
            issue_op(make_word(op, 0, 0, 0), $urandom(), $urandom());
            issue_op(make_word(op, 7, 0, 0), $urandom(), $urandom());
        end
        drain();
        end_test("illegal");

        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
logic/cop_isa_pkg.sv
logic/cop_pipe_pkg.sv
logic/cop_palu_shifter.sv
logic/cop_palu_adder.sv
logic/cop_palu_decode.sv
logic/cop_palu_execute.sv
logic/cop_palu_result.sv
logic/cop_palu_top.sv
testbench/tb_cop_palu_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the packed ALU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cop_palu_top -f tb.f -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0
